// ==== dag_pkg.sv ====
`default_nettype none

package dag_pkg;

    parameter int DEF_NODE_WIDTH   = 15;   // three letters, 5 bits each
    parameter int DEF_MAX_NODE_QTY = 1024;
    parameter int DEF_MAX_EDGE_QTY = 2048;
    parameter int DEF_COUNT_WIDTH  = 16;

    localparam byte A_CHAR = 8'h61;        // lower case a

    // first letter lands in the low bits
    function automatic logic [DEF_NODE_WIDTH-1:0] node_from_ascii(input string name);
        node_from_ascii[4:0]   = 5'(name[0] - A_CHAR);
        node_from_ascii[9:5]   = 5'(name[1] - A_CHAR);
        node_from_ascii[14:10] = 5'(name[2] - A_CHAR);
    endfunction

    function automatic string node_to_ascii(input logic [DEF_NODE_WIDTH-1:0] node);
        node_to_ascii    = "aaa";
        node_to_ascii[0] = 8'(node[4:0] + A_CHAR);
        node_to_ascii[1] = 8'(node[9:5] + A_CHAR);
        node_to_ascii[2] = 8'(node[14:10] + A_CHAR);
    endfunction

endpackage

`default_nettype wire

// ==== node_id_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module node_id_mapper
    import dag_pkg::*;
#(
    parameter int  NODE_WIDTH   = DEF_NODE_WIDTH,
    parameter int  MAX_NODE_QTY = DEF_MAX_NODE_QTY,
    localparam int ID_W         = $clog2(MAX_NODE_QTY)
)(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  edge_valid,
    input  wire                  edge_last,
    input  wire [NODE_WIDTH-1:0] src_node,
    input  wire [NODE_WIDTH-1:0] dst_node,
    input  wire [NODE_WIDTH-1:0] start_node,
    input  wire [NODE_WIDTH-1:0] end_node,
    output logic                 map_valid,
    output logic [ID_W-1:0]      src_id,
    output logic [ID_W-1:0]      dst_id,
    output logic                 new_src,
    output logic                 build_done,
    output logic [ID_W:0]        node_qty,
    output logic [ID_W-1:0]      start_id,
    output logic                 start_known,
    output logic [ID_W-1:0]      end_id,
    output logic                 end_known
);

    logic [2**NODE_WIDTH-1:0] assigned;          // one flag per possible name
    logic [ID_W-1:0]          id_tab [2**NODE_WIDTH];
    logic [ID_W:0]            node_idx;          // next free id
    logic [NODE_WIDTH-1:0]    prev_src;
    logic                     have_prev;
    logic                     last_q;
    logic                     src_known;
    logic                     dst_known;
    logic                     dst_same;
    logic [ID_W-1:0]          src_id_c;
    logic [ID_W-1:0]          dst_id_c;

    always_comb begin
        src_known = assigned[src_node];
        dst_known = assigned[dst_node];
        dst_same  = (dst_node == src_node);       // self-loop takes a single id
        src_id_c  = src_known ? id_tab[src_node] : node_idx[ID_W-1:0];
        if (dst_known)
            dst_id_c = id_tab[dst_node];
        else if (dst_same)
            dst_id_c = src_id_c;
        else
            dst_id_c = node_idx[ID_W-1:0] + ID_W'(!src_known);  // source goes first
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            assigned   <= '0;
            node_idx   <= '0;
            have_prev  <= 1'b0;
            map_valid  <= 1'b0;
            last_q     <= 1'b0;
            build_done <= 1'b0;
        end else begin
            map_valid  <= edge_valid;
            last_q     <= edge_valid && edge_last;
            build_done <= last_q;                  // one cycle after the last mapped edge
            if (edge_valid) begin
                assigned[src_node] <= 1'b1;
                assigned[dst_node] <= 1'b1;
                node_idx  <= node_idx + (ID_W+1)'(!src_known)
                                      + (ID_W+1)'(!dst_known && !dst_same);
                have_prev <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (edge_valid) begin
            if (!src_known)
                id_tab[src_node] <= src_id_c;
            if (!dst_known)
                id_tab[dst_node] <= dst_id_c;
            src_id   <= src_id_c;
            dst_id   <= dst_id_c;
            new_src  <= !have_prev || (src_node != prev_src);
            prev_src <= src_node;
        end
    end

    assign node_qty    = node_idx;
    assign start_known = assigned[start_node];
    assign start_id    = id_tab[start_node];
    assign end_known   = assigned[end_node];
    assign end_id      = id_tab[end_node];

    a_node_cap: assert property (@(posedge clk) disable iff (!rst_n)
        node_idx <= (ID_W+1)'(MAX_NODE_QTY))
        else $error("node capacity exceeded");

endmodule

`default_nettype wire

// ==== degree_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module degree_counter
    import dag_pkg::*;
#(
    parameter int  MAX_NODE_QTY = DEF_MAX_NODE_QTY,
    localparam int ID_W         = $clog2(MAX_NODE_QTY)
)(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            map_valid,
    input  wire [ID_W-1:0] dst_id,
    input  wire [ID_W-1:0] deg_rd_id,
    input  wire            dec_valid,
    input  wire [ID_W-1:0] dec_id,
    output logic           deg_zero,
    output logic           became_zero
);

    logic [ID_W:0] in_deg [MAX_NODE_QTY];

    // build and sort never overlap, increments only arrive during build
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MAX_NODE_QTY; i++)
                in_deg[i] <= '0;
        end else if (map_valid) begin
            in_deg[dst_id] <= in_deg[dst_id] + 1'b1;
        end else if (dec_valid) begin
            in_deg[dec_id] <= in_deg[dec_id] - 1'b1;
        end
    end

    assign deg_zero    = (in_deg[deg_rd_id] == '0);
    assign became_zero = (in_deg[dec_id] == (ID_W+1)'(1));  // last incoming edge removed

    // the sorter may only remove edges that were counted during build
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> in_deg[dec_id] != '0)
        else $error("in-degree decrement below zero at id %0d", dec_id);

endmodule

`default_nettype wire

// ==== adjacency_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module adjacency_store
    import dag_pkg::*;
#(
    parameter int  MAX_NODE_QTY = DEF_MAX_NODE_QTY,
    parameter int  MAX_EDGE_QTY = DEF_MAX_EDGE_QTY,
    localparam int ID_W         = $clog2(MAX_NODE_QTY),
    localparam int PTR_W        = $clog2(MAX_EDGE_QTY)
)(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             map_valid,
    input  wire [ID_W-1:0]  src_id,
    input  wire [ID_W-1:0]  dst_id,
    input  wire             new_src,
    input  wire [ID_W-1:0]  adj_rd_id,
    input  wire [PTR_W-1:0] edge_rd_ptr,
    output logic [PTR_W-1:0] first_ptr,
    output logic [PTR_W:0]   out_count,
    output logic [ID_W-1:0]  edge_dst
);

    logic [PTR_W-1:0] first_tab [MAX_NODE_QTY];   // first edge of each source
    logic [PTR_W:0]   cnt_tab   [MAX_NODE_QTY];   // out-degree of each source
    logic [ID_W-1:0]  dst_mem   [MAX_EDGE_QTY];   // destinations, grouped by source
    logic [PTR_W:0]   wr_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            for (int i = 0; i < MAX_NODE_QTY; i++)
                cnt_tab[i] <= '0;
        end else if (map_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (new_src)
                cnt_tab[src_id] <= (PTR_W+1)'(1);
            else
                cnt_tab[src_id] <= cnt_tab[src_id] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (map_valid) begin
            dst_mem[wr_ptr[PTR_W-1:0]] <= dst_id;
            if (new_src)
                first_tab[src_id] <= wr_ptr[PTR_W-1:0];
        end
    end

    assign first_ptr = first_tab[adj_rd_id];
    assign out_count = cnt_tab[adj_rd_id];
    assign edge_dst  = dst_mem[edge_rd_ptr];

    a_edge_cap: assert property (@(posedge clk) disable iff (!rst_n)
        map_valid |-> wr_ptr < (PTR_W+1)'(MAX_EDGE_QTY))
        else $error("edge capacity exceeded");

    // a source seen again later means the stream was not grouped by source
    a_grouped: assert property (@(posedge clk) disable iff (!rst_n)
        map_valid && new_src |-> cnt_tab[src_id] == '0)
        else $error("edges of source id %0d are not grouped", src_id);

endmodule

`default_nettype wire

// ==== path_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module path_counter
    import dag_pkg::*;
#(
    parameter int  MAX_NODE_QTY = DEF_MAX_NODE_QTY,
    parameter int  MAX_EDGE_QTY = DEF_MAX_EDGE_QTY,
    parameter int  COUNT_WIDTH  = DEF_COUNT_WIDTH,
    localparam int ID_W         = $clog2(MAX_NODE_QTY),
    localparam int PTR_W        = $clog2(MAX_EDGE_QTY)
)(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    build_done,
    input  wire [ID_W:0]           node_qty,
    input  wire [ID_W-1:0]         start_id,
    input  wire                    start_known,
    input  wire [ID_W-1:0]         end_id,
    input  wire                    end_known,
    input  wire                    deg_zero,
    input  wire                    became_zero,
    input  wire [PTR_W-1:0]        first_ptr,
    input  wire [PTR_W:0]          out_count,
    input  wire [ID_W-1:0]         edge_dst,
    output logic [ID_W-1:0]        deg_rd_id,
    output logic                   dec_valid,
    output logic [ID_W-1:0]        dec_id,
    output logic [ID_W-1:0]        adj_rd_id,
    output logic [PTR_W-1:0]       edge_rd_ptr,
    output logic                   done,
    output logic [COUNT_WIDTH-1:0] path_count,
    output logic                   cycle_error
);

    typedef enum logic [1:0] {IDLE, SCAN, POP, WALK} state_t;

    state_t                 state;
    logic [COUNT_WIDTH-1:0] cnt_mem [MAX_NODE_QTY];   // paths from start per id
    logic [ID_W-1:0]        queue   [MAX_NODE_QTY];   // each id is pushed at most once
    logic [ID_W:0]          scan_id;
    logic [ID_W:0]          q_head;
    logic [ID_W:0]          q_tail;
    logic [ID_W:0]          popped;
    logic [COUNT_WIDTH-1:0] cur_cnt;
    logic [PTR_W-1:0]       walk_ptr;
    logic [PTR_W:0]         walk_left;
    logic                   scan_busy;
    logic                   walk_busy;
    logic                   q_empty;
    logic                   push;
    logic [ID_W-1:0]        push_id;
    logic [ID_W-1:0]        head_id;
    logic [COUNT_WIDTH:0]   sum;

    assign scan_busy   = (state == SCAN) && (scan_id != node_qty);
    assign walk_busy   = (state == WALK) && (walk_left != '0);
    assign q_empty     = (q_head == q_tail);
    assign head_id     = queue[q_head[ID_W-1:0]];
    assign deg_rd_id   = scan_id[ID_W-1:0];
    assign adj_rd_id   = head_id;
    assign edge_rd_ptr = walk_ptr;
    assign dec_valid   = walk_busy;                   // one edge removed per walk cycle
    assign dec_id      = edge_dst;
    assign sum         = {1'b0, cnt_mem[edge_dst]} + {1'b0, cur_cnt};
    assign push        = (scan_busy && deg_zero) || (walk_busy && became_zero);
    assign push_id     = scan_busy ? scan_id[ID_W-1:0] : edge_dst;

    always_ff @(posedge clk) begin
        if (scan_busy)
            cnt_mem[scan_id[ID_W-1:0]] <= (start_known && scan_id[ID_W-1:0] == start_id) ?
                                          COUNT_WIDTH'(1) : '0;
        else if (walk_busy)
            cnt_mem[edge_dst] <= sum[COUNT_WIDTH] ? '1 : sum[COUNT_WIDTH-1:0];  // saturate
        if (push)
            queue[q_tail[ID_W-1:0]] <= push_id;
    end

    // load the popped node's count and edge range
    always_ff @(posedge clk) begin
        if (state == POP && !q_empty) begin
            cur_cnt   <= cnt_mem[head_id];
            walk_ptr  <= first_ptr;
            walk_left <= out_count;
        end else if (walk_busy) begin
            walk_ptr  <= walk_ptr + 1'b1;
            walk_left <= walk_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            done        <= 1'b0;
            path_count  <= '0;
            cycle_error <= 1'b0;
            scan_id     <= '0;
            q_head      <= '0;
            q_tail      <= '0;
            popped      <= '0;
        end else begin
            done <= 1'b0;
            if (push)
                q_tail <= q_tail + 1'b1;
            case (state)
                IDLE: if (build_done) state <= SCAN;
                SCAN: begin
                    if (scan_busy)
                        scan_id <= scan_id + 1'b1;
                    else
                        state <= POP;
                end
                POP: begin
                    if (q_empty) begin
                        done        <= 1'b1;
                        path_count  <= end_known ? cnt_mem[end_id] : '0;
                        cycle_error <= (popped != node_qty);  // ids left on a cycle
                        state       <= IDLE;
                    end else begin
                        q_head <= q_head + 1'b1;
                        popped <= popped + 1'b1;
                        state  <= WALK;
                    end
                end
                WALK: if (!walk_busy) state <= POP;
                default: state <= IDLE;
            endcase
        end
    end

    a_queue_cap: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> q_tail < (ID_W+1)'(MAX_NODE_QTY))
        else $error("topological queue overflow");

endmodule

`default_nettype wire

// ==== dag_path_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dag_path_top
    import dag_pkg::*;
#(
    parameter int  NODE_WIDTH   = DEF_NODE_WIDTH,
    parameter int  MAX_NODE_QTY = DEF_MAX_NODE_QTY,
    parameter int  MAX_EDGE_QTY = DEF_MAX_EDGE_QTY,
    parameter int  COUNT_WIDTH  = DEF_COUNT_WIDTH,
    localparam int ID_W         = $clog2(MAX_NODE_QTY),
    localparam int PTR_W        = $clog2(MAX_EDGE_QTY)
)(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    edge_valid,
    input  wire                    edge_last,   // rides with the final edge
    input  wire [NODE_WIDTH-1:0]   src_node,
    input  wire [NODE_WIDTH-1:0]   dst_node,
    input  wire [NODE_WIDTH-1:0]   start_node,
    input  wire [NODE_WIDTH-1:0]   end_node,
    output logic                   done,
    output logic [COUNT_WIDTH-1:0] path_count,
    output logic                   cycle_error
);

    logic             map_valid;
    logic [ID_W-1:0]  src_id;
    logic [ID_W-1:0]  dst_id;
    logic             new_src;
    logic             build_done;
    logic [ID_W:0]    node_qty;
    logic [ID_W-1:0]  start_id;
    logic             start_known;
    logic [ID_W-1:0]  end_id;
    logic             end_known;
    logic [ID_W-1:0]  deg_rd_id;
    logic             deg_zero;
    logic             dec_valid;
    logic [ID_W-1:0]  dec_id;
    logic             became_zero;
    logic [ID_W-1:0]  adj_rd_id;
    logic [PTR_W-1:0] first_ptr;
    logic [PTR_W:0]   out_count;
    logic [PTR_W-1:0] edge_rd_ptr;
    logic [ID_W-1:0]  edge_dst;

    node_id_mapper #(
        .NODE_WIDTH   (NODE_WIDTH),
        .MAX_NODE_QTY (MAX_NODE_QTY)
    ) i_node_id_mapper (
        .clk, .rst_n, .edge_valid, .edge_last, .src_node, .dst_node,
        .start_node, .end_node, .map_valid, .src_id, .dst_id, .new_src,
        .build_done, .node_qty, .start_id, .start_known, .end_id, .end_known
    );

    degree_counter #(
        .MAX_NODE_QTY (MAX_NODE_QTY)
    ) i_degree_counter (
        .clk, .rst_n, .map_valid, .dst_id, .deg_rd_id, .dec_valid, .dec_id,
        .deg_zero, .became_zero
    );

    adjacency_store #(
        .MAX_NODE_QTY (MAX_NODE_QTY),
        .MAX_EDGE_QTY (MAX_EDGE_QTY)
    ) i_adjacency_store (
        .clk, .rst_n, .map_valid, .src_id, .dst_id, .new_src, .adj_rd_id,
        .edge_rd_ptr, .first_ptr, .out_count, .edge_dst
    );

    path_counter #(
        .MAX_NODE_QTY (MAX_NODE_QTY),
        .MAX_EDGE_QTY (MAX_EDGE_QTY),
        .COUNT_WIDTH  (COUNT_WIDTH)
    ) i_path_counter (
        .clk, .rst_n, .build_done, .node_qty, .start_id, .start_known,
        .end_id, .end_known, .deg_zero, .became_zero, .first_ptr, .out_count,
        .edge_dst, .deg_rd_id, .dec_valid, .dec_id, .adj_rd_id, .edge_rd_ptr,
        .done, .path_count, .cycle_error
    );

endmodule

`default_nettype wire

// ==== dag_path_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dag_path_checker
    import dag_pkg::*;
#(
    parameter int COUNT_WIDTH = DEF_COUNT_WIDTH
)(
    input wire                   clk,
    input wire                   rst_n,
    input wire                   done,
    input wire [COUNT_WIDTH-1:0] path_count,
    input wire                   cycle_error
);

    string                  test_name;
    string                  route;            // start and end names for messages
    logic [COUNT_WIDTH-1:0] exp_count;
    logic                   exp_cycle;
    bit                     pending  = 1'b0;  // a test is waiting for done
    int                     pass_qty = 0;
    int                     fail_qty = 0;

    task automatic expect_result(input string name,
                                 input logic [DEF_NODE_WIDTH-1:0] from,
                                 input logic [DEF_NODE_WIDTH-1:0] to,
                                 input logic [COUNT_WIDTH-1:0] count,
                                 input logic cyc);
        if (pending) begin
            $display("%s: no done pulse before the next test started", test_name);
            fail_qty++;
        end
        test_name = name;
        route     = $sformatf("%s -> %s", node_to_ascii(from), node_to_ascii(to));
        exp_count = count;
        exp_cycle = cyc;
        pending   = 1'b1;
    endtask

    // path_count only means something for an acyclic graph
    always @(posedge clk) begin
        if (rst_n && done) begin
            if (!pending) begin
                $display("done pulse seen while no test was running");
                fail_qty++;
            end else if (cycle_error !== exp_cycle) begin
                $display("** Error %s (%s): expected cycle_error %0b, actual %0b",
                         test_name, route, exp_cycle, cycle_error);
                fail_qty++;
            end else if (!exp_cycle && path_count !== exp_count) begin
                $display("** Error %s (%s): expected path_count %0d, actual %0d",
                         test_name, route, exp_count, path_count);
                fail_qty++;
            end else begin
                $display("ok %s (%s): path_count %0d, cycle_error %0b",
                         test_name, route, path_count, cycle_error);
                pass_qty++;
            end
            pending = 1'b0;
        end
    end

    task automatic report();
        if (pending) begin
            $display("%s: no done pulse before the end of the run", test_name);
            fail_qty++;
            pending = 1'b0;
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 pass_qty + fail_qty, pass_qty, fail_qty);
    endtask

endmodule

`default_nettype wire

// ==== tb_dag_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dag_path
    import dag_pkg::*;
();

    localparam int          COUNT_W   = 16;
    localparam int unsigned COUNT_MAX = (1 << COUNT_W) - 1;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      edge_valid;
    logic                      edge_last;
    logic [DEF_NODE_WIDTH-1:0] src_node;
    logic [DEF_NODE_WIDTH-1:0] dst_node;
    logic [DEF_NODE_WIDTH-1:0] start_node;
    logic [DEF_NODE_WIDTH-1:0] end_node;
    logic                      done;
    logic [COUNT_W-1:0]        path_count;
    logic                      cycle_error;

    logic [DEF_NODE_WIDTH-1:0] e_src [$];      // edge list of the current graph
    logic [DEF_NODE_WIDTH-1:0] e_dst [$];
    logic [DEF_NODE_WIDTH-1:0] nodes [$];      // distinct names seen by the reference
    int                        seed;
    int unsigned               budget = 2000;  // watchdog limit in cycles that grows per test

    always #50 clk = ~clk;

    dag_path_top #(
        .COUNT_WIDTH (COUNT_W)
    ) i_dag_path_top (
        .clk, .rst_n, .edge_valid, .edge_last, .src_node, .dst_node,
        .start_node, .end_node, .done, .path_count, .cycle_error
    );

    dag_path_checker #(
        .COUNT_WIDTH (COUNT_W)
    ) i_checker (
        .clk, .rst_n, .done, .path_count, .cycle_error
    );

    function automatic string idx_name(input byte lead, input int i);
        return $sformatf("%c%c%c", lead, 8'h61 + i / 26, 8'h61 + i % 26);
    endfunction

    function automatic void add_edge(input string s, input string d);
        e_src.push_back(node_from_ascii(s));
        e_dst.push_back(node_from_ascii(d));
    endfunction

    function automatic int node_index(input logic [DEF_NODE_WIDTH-1:0] name);
        foreach (nodes[k])
            if (nodes[k] == name)
                return k;
        return -1;
    endfunction

    // kahn order over the edge list with counts saturating at COUNT_MAX
    function automatic int unsigned ref_paths(input logic [DEF_NODE_WIDTH-1:0] from,
                                              input logic [DEF_NODE_WIDTH-1:0] to,
                                              output bit cyc);
        int unsigned cnt [$];
        int          indeg [$];
        int          ready [$];
        int          popped;
        int          u;
        int          d;
        nodes.delete();
        foreach (e_src[k]) begin
            if (node_index(e_src[k]) < 0)
                nodes.push_back(e_src[k]);
            if (node_index(e_dst[k]) < 0)
                nodes.push_back(e_dst[k]);
        end
        foreach (nodes[k]) begin
            cnt.push_back((nodes[k] == from) ? 1 : 0);
            indeg.push_back(0);
        end
        foreach (e_dst[k])
            indeg[node_index(e_dst[k])]++;
        foreach (indeg[k])
            if (indeg[k] == 0)
                ready.push_back(k);
        popped = 0;
        while (ready.size() > 0) begin
            u = ready.pop_front();
            popped++;
            foreach (e_src[k]) begin
                if (node_index(e_src[k]) == u) begin
                    d = node_index(e_dst[k]);
                    cnt[d] = (cnt[d] + cnt[u] > COUNT_MAX) ? COUNT_MAX : cnt[d] + cnt[u];
                    indeg[d]--;
                    if (indeg[d] == 0)
                        ready.push_back(d);
                end
            end
        end
        cyc = (popped != nodes.size());
        d = node_index(to);
        return (d < 0) ? 0 : cnt[d];
    endfunction

    function automatic void fixed_graph();
        e_src.delete();
        e_dst.delete();
        add_edge("you", "bbb");
        add_edge("you", "ccc");
        add_edge("bbb", "ddd");
        add_edge("ccc", "ddd");
        add_edge("ccc", "eee");   // eee and fff lead nowhere
        add_edge("ddd", "out");
        add_edge("ddd", "ggg");
        add_edge("eee", "fff");
        add_edge("ggg", "out");
    endfunction

    task automatic make_random_dag(output string from, output string to);
        int n;
        n = 10 + $unsigned($random(seed)) % 51;
        e_src.delete();
        e_dst.delete();
        for (int s = 0; s < n; s++)
            for (int d = s + 1; d < n; d++)
                if ($unsigned($random(seed)) % 5 == 0)
                    add_edge(idx_name("r", s), idx_name("r", d));
        if (e_src.size() == 0)
            add_edge(idx_name("r", 0), idx_name("r", 1));
        from = idx_name("r", $unsigned($random(seed)) % (n / 3));
        to   = idx_name("r", n - 1 - $unsigned($random(seed)) % (n / 3));
    endtask

    task automatic run_graph(input string name, input string from, input string to,
                             input bit gaps);
        int unsigned exp_cnt;
        bit          exp_cyc;
        int unsigned limit;
        exp_cnt = ref_paths(node_from_ascii(from), node_from_ascii(to), exp_cyc);
        budget += 40 * e_src.size() + 2000;
        i_checker.expect_result(name, node_from_ascii(from), node_from_ascii(to),
                                exp_cnt[COUNT_W-1:0], exp_cyc);
        @(posedge clk);
        rst_n      <= 1'b0;
        start_node <= node_from_ascii(from);
        end_node   <= node_from_ascii(to);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        foreach (e_src[k]) begin
            @(posedge clk);
            edge_valid <= 1'b1;
            edge_last  <= (k == e_src.size() - 1);
            src_node   <= e_src[k];
            dst_node   <= e_dst[k];
            if (gaps) begin
                repeat ($unsigned($random(seed)) % 3) begin
                    @(posedge clk);
                    edge_valid <= 1'b0;
                    edge_last  <= 1'b0;
                end
            end
        end
        @(posedge clk);
        edge_valid <= 1'b0;
        edge_last  <= 1'b0;
        limit = 20 * e_src.size() + 1000;
        while (!done && limit > 0) begin
            @(posedge clk);
            limit--;
        end
        @(negedge clk);   // checker has sampled done by now
    endtask

    initial begin
        string from;
        string to;
        seed       = 32'h4a3c;
        rst_n      = 1'b0;
        edge_valid = 1'b0;
        edge_last  = 1'b0;
        src_node   = '0;
        dst_node   = '0;
        start_node = '0;
        end_node   = '0;

        fixed_graph();
        run_graph("fixed_you_out", "you", "out", 1'b0);
        for (int t = 0; t < 10; t++) begin
            make_random_dag(from, to);
            run_graph($sformatf("random_dag_%0d", t), from, to, 1'b1);
        end
        fixed_graph();
        run_graph("unknown_start", "zzz", "out", 1'b0);
        run_graph("unreachable_end", "bbb", "eee", 1'b1);

        e_src.delete();
        e_dst.delete();
        add_edge("you", "aaa");
        add_edge("aaa", "bbb");
        add_edge("bbb", "ccc");
        add_edge("ccc", "aaa");     // closes the loop
        add_edge("ccc", "out");
        run_graph("cycle_in_middle", "you", "out", 1'b0);

        e_src.delete();
        e_dst.delete();
        for (int i = 0; i < 20; i++) begin
            add_edge(idx_name("j", i), idx_name("a", i));
            add_edge(idx_name("j", i), idx_name("b", i));
            add_edge(idx_name("a", i), idx_name("j", i + 1));
            add_edge(idx_name("b", i), idx_name("j", i + 1));
        end
        run_graph("diamond_chain_saturate", idx_name("j", 0), idx_name("j", 20), 1'b0);

        e_src.delete();
        e_dst.delete();
        add_edge("aaa", "bbb");
        add_edge("bbb", "ccc");
        add_edge("bbb", "ddd");
        add_edge("ccc", "ddd");
        add_edge("ccc", "eee");
        add_edge("ddd", "eee");
        run_graph("shared_ids", "aaa", "eee", 1'b1);

        i_checker.report();
        if (i_checker.fail_qty == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog: run did not finish within %0d cycles", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
dag_pkg.sv
node_id_mapper.sv
degree_counter.sv
adjacency_store.sv
path_counter.sv
dag_path_top.sv
dag_path_checker.sv
tb_dag_path.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dag_path -f build.f -o sim_dag_path

./obj_dir/sim_dag_path | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1
